// ==== tb.f ====
design/class_pkg.sv
design/class_key_hash.sv
design/class_hash_table.sv
design/class_hbkt_cmp.sv
design/class_lookup_top.sv
tests/class_lookup_asserts.sv
tests/class_lookup_tb.sv

// ==== Makefile ====
# Verilator build and run for the classifier lookup front end

VERILATOR ?= verilator
TOP       ?= class_lookup_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/class_lookup_tb.sv ====
// ======================================
// Lookup front end testbench
// Loads both tables, runs directed and
// random keys, checks every result window
// ======================================
`timescale 1ns/1ps
`default_nettype none

module class_lookup_tb
    import class_pkg::*;
();

    // ======================================
    // Constants
    localparam int CLK_PERIOD      = 4;
    localparam int RST_CYCLES      = 5;
    localparam int NUM_RANDOM      = 200;
    localparam int NUM_LOOKUPS     = NUM_RANDOM + 6;
    // Table clears, random fill, directed and forced writes
    localparam int LOAD_CYCLES     = 640;
    localparam int MARGIN          = 200;
    localparam int WATCHDOG_CYCLES = NUM_LOOKUPS * 8 + LOAD_CYCLES + MARGIN;

    // Key in flight and the edge that sampled it
    typedef struct packed {
        logic [31:0] key;
        int          issue_edge;
    } pending_t;

    // Expected result window
    typedef struct packed {
        logic       err;
        logic [2:0] hits;
        ptr_t [3:0] ptrs;
    } expect_t;

    // DUT ports
    logic        clk;
    logic        rst_n;
    logic        key_vld;
    logic [31:0] key;
    logic        tbl_wr_en;
    bkt_wr_t     tbl_wr;
    logic        pkt_strobe;
    logic        ptr_hit_miss;
    ptr_t        ptr;
    logic        pkt_err;

    // Bookkeeping
    integer      seed;
    int          cyc      = 0;
    int          errors   = 0;
    int          issued   = 0;
    int          done_cnt = 0;
    pending_t    issue_q [$];
    bkt_t        t1_model [NUM_BKTS];
    bkt_t        t2_model [NUM_BKTS];
    logic [31:0] rand_keys [NUM_RANDOM];

    class_lookup_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_vld      (key_vld),
        .key          (key),
        .tbl_wr_en    (tbl_wr_en),
        .tbl_wr       (tbl_wr),
        .pkt_strobe   (pkt_strobe),
        .ptr_hit_miss (ptr_hit_miss),
        .ptr          (ptr),
        .pkt_err      (pkt_err)
    );

    // ======================================
    // Clock and edge counter
    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // ======================================
    // Model helpers
    // Both hashes of a key as {h1k, h2k}
    function automatic logic [25:0] key_hashes(input logic [31:0] k);
        logic [31:0] rot;
        hash_t       h1;
        hash_t       h2;
        rot = {k[24:0], k[31:25]};
        h1  = k[12:0] ^ k[25:13] ^ {7'b0, k[31:26]};
        h2  = rot[12:0] ^ rot[25:13] ^ {7'b0, rot[31:26]};
        return {h1, h2};
    endfunction

    function automatic logic [31:0] make_way(input logic vld, input ptr_t p, input hash_t h);
        return {vld, p, 3'b000, h};
    endfunction

    // Expected pointers, hit count and overflow for one key
    function automatic expect_t ref_lookup(input logic [31:0] k, input bkt_t t1 [NUM_BKTS],
                                           input bkt_t t2 [NUM_BKTS]);
        expect_t     r;
        logic [25:0] hh;
        bkt_t        b1;
        bkt_t        b2;
        logic [31:0] word;
        hash_t       want_hash;
        int          n;
        r  = '0;
        n  = 0;
        hh = key_hashes(k);
        b1 = t1[hh[18:13]];
        b2 = t2[hh[5:0]];
        // Table 1 ways first, then table 2
        for (int i = 0; i < 2 * WAYS; i++)
        begin
            word      = (i < WAYS) ? b1[i*32 +: 32] : b2[(i-WAYS)*32 +: 32];
            want_hash = (i < WAYS) ? hh[12:0] : hh[25:13];
            if (word[31] && word[12:0] == want_hash)
            begin
                if (n < 4)
                    r.ptrs[2'(n)] = word[30:16];
                n = n + 1;
            end
        end
        r.hits = 3'((n > 4) ? 4 : n);
        r.err  = (n > 4);
        return r;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want)
        begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, want);
            errors++;
        end
    endtask

    // ======================================
    // Drivers, all entered 1 ns after a rising edge
    task automatic write_bucket(input logic sel, input bkt_addr_t addr, input bkt_t data);
        tbl_wr_en      = 1'b1;
        tbl_wr.tbl_sel = sel;
        tbl_wr.addr    = addr;
        tbl_wr.data    = data;
        if (sel)
            t2_model[addr] = data;
        else
            t1_model[addr] = data;
        @(posedge clk);
        #1;
        tbl_wr_en = 1'b0;
    endtask

    // Read-modify-write of one way
    task automatic set_way(input logic sel, input bkt_addr_t addr, input int way,
                           input logic [31:0] word);
        bkt_t data;
        data = sel ? t2_model[addr] : t1_model[addr];
        data[way*32 +: 32] = word;
        write_bucket(sel, addr, data);
    endtask

    // Place a way holding the key's alternate hash
    task automatic force_match(input logic [31:0] k, input logic sel, input int way,
                               input ptr_t p, input logic vld);
        logic [25:0] hh;
        hh = key_hashes(k);
        if (sel)
            set_way(1'b1, hh[5:0], way, make_way(vld, p, hh[25:13]));
        else
            set_way(1'b0, hh[18:13], way, make_way(vld, p, hh[12:0]));
    endtask

    // One key, then three idle cycles
    task automatic lookup(input logic [31:0] k);
        pending_t p;
        key_vld      = 1'b1;
        key          = k;
        p.key        = k;
        p.issue_edge = cyc + 1;
        issue_q.push_back(p);
        issued++;
        @(posedge clk);
        #1;
        key_vld = 1'b0;
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic wait_idle();
        while (done_cnt != issued)
            @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
    endtask

    // ======================================
    // Result checker
    initial
    begin
        pending_t p;
        expect_t  want;
        ptr_t     want_ptr;
        int       cur;
        forever
        begin
            @(posedge clk);
            cur = cyc + 1;
            if (pkt_strobe === 1'b1)
            begin
                if (issue_q.size() == 0)
                begin
                    $display("ERROR: pkt_strobe at %0t with no lookup pending", $time);
                    errors++;
                end
                else
                begin
                    p    = issue_q.pop_front();
                    check_value(cur, p.issue_edge + 5, "strobe edge");
                    want = ref_lookup(p.key, t1_model, t2_model);
                    // Four result cycles, T+5 to T+8
                    for (int w = 0; w < 4; w++)
                    begin
                        if (w > 0)
                        begin
                            @(posedge clk);
                            check_value(32'(pkt_strobe), 32'h0, "pkt_strobe repeat");
                        end
                        want_ptr = (w < int'(want.hits)) ? want.ptrs[2'(w)] : '0;
                        check_value(32'(ptr_hit_miss), 32'(w < int'(want.hits)), "ptr_hit_miss");
                        check_value(32'(ptr), 32'(want_ptr), "ptr");
                        check_value(32'(pkt_err), 32'((w == 3) && want.err), "pkt_err");
                    end
                    done_cnt++;
                end
            end
            else if (cur >= 2)
            begin
                // Quiet outside a result window, reset included
                check_value(32'(ptr_hit_miss), 32'h0, "idle ptr_hit_miss");
                check_value(32'(pkt_err), 32'h0, "idle pkt_err");
                check_value(32'(ptr), 32'h0, "idle ptr");
            end
        end
    end

    // ======================================
    // Watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired, checked %0d of %0d lookups", done_cnt, issued);
        $display("** FAIL **");
        $finish;
    end

    // ======================================
    // Stimulus
    initial
    begin
        logic [31:0] k;
        logic [25:0] hh;
        bkt_t        b;
        int          way;
        seed      = 81;
        rst_n     = 1'b0;
        key_vld   = 1'b0;
        key       = '0;
        tbl_wr_en = 1'b0;
        tbl_wr    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // No way valid to start with
        for (int a = 0; a < NUM_BKTS; a++)
        begin
            write_bucket(1'b0, bkt_addr_t'(a), '0);
            write_bucket(1'b1, bkt_addr_t'(a), '0);
        end

        // Single hit in table 1
        force_match(32'h1234_5678, 1'b0, 2, 15'h1abc, 1'b1);
        lookup(32'h1234_5678);
        wait_idle();

        // Miss on a wrong hash, then on a matching way left invalid
        k  = 32'h0bad_cafe;
        hh = key_hashes(k);
        set_way(1'b0, hh[18:13], 0, make_way(1'b1, 15'h0077, hh[12:0] ^ 13'h1));
        lookup(k);
        wait_idle();
        force_match(k, 1'b1, 1, 15'h0055, 1'b0);
        lookup(k);
        wait_idle();

        // Three and four hits across both tables
        k = 32'h5a5a_0f0f;
        force_match(k, 1'b0, 1, 15'h0101, 1'b1);
        force_match(k, 1'b1, 0, 15'h0202, 1'b1);
        force_match(k, 1'b1, 3, 15'h0303, 1'b1);
        lookup(k);
        wait_idle();
        k = 32'hdead_beef;
        force_match(k, 1'b0, 0, 15'h0a00, 1'b1);
        force_match(k, 1'b0, 3, 15'h0a03, 1'b1);
        force_match(k, 1'b1, 1, 15'h0b01, 1'b1);
        force_match(k, 1'b1, 2, 15'h0b02, 1'b1);
        lookup(k);
        wait_idle();

        // Six matches, overflow
        k = 32'h1357_9bdf;
        for (int w = 0; w < WAYS; w++)
            force_match(k, 1'b0, w, ptr_t'(32'h400 + w), 1'b1);
        force_match(k, 1'b1, 0, 15'h0500, 1'b1);
        force_match(k, 1'b1, 2, 15'h0502, 1'b1);
        lookup(k);
        wait_idle();

        // Random fill, zero bits of each way kept clear
        for (int a = 0; a < NUM_BKTS; a++)
        begin
            for (int t = 0; t < 2; t++)
            begin
                for (int w = 0; w < WAYS; w++)
                    b[w*32 +: 32] = $random(seed) & 32'hffff_1fff;
                write_bucket(t[0], bkt_addr_t'(a), b);
            end
        end

        // Random keys, some with forced matches
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            rand_keys[i] = $random(seed);
            way          = $unsigned($random(seed)) % WAYS;
            if (i % 4 == 1)
                force_match(rand_keys[i], 1'b0, way, ptr_t'($random(seed)), 1'b1);
            if (i % 8 == 3)
            begin
                force_match(rand_keys[i], 1'b0, way, ptr_t'($random(seed)), 1'b1);
                force_match(rand_keys[i], 1'b1, way, ptr_t'($random(seed)), 1'b1);
            end
            if (i % 20 == 7)
            begin
                for (int w = 0; w < WAYS; w++)
                    force_match(rand_keys[i], 1'b0, w, ptr_t'($random(seed)), 1'b1);
                force_match(rand_keys[i], 1'b1, way, ptr_t'($random(seed)), 1'b1);
            end
        end
        for (int i = 0; i < NUM_RANDOM; i++)
            lookup(rand_keys[i]);
        wait_idle();

        $display("lookups %0d, checked %0d, errors %0d", issued, done_cnt, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/class_lookup_asserts.sv ====
// ======================================
// Comparator output checks
// Bound into the bucket comparator
// ======================================
`timescale 1ns/1ps
`default_nettype none

module class_lookup_asserts
    import class_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic pkt_strobe,
    input logic pkt_err,
    input logic ptr_hit_miss,
    input ptr_t ptr
);

    // Outputs are unknown before the first edge
    logic clk_seen = 1'b0;

    always @(posedge clk)
        clk_seen <= 1'b1;

    // Quiet while reset is held
    reset_quiet: assert property (@(posedge clk)
        (clk_seen && !rst_n) |-> (!pkt_strobe && !ptr_hit_miss && !pkt_err && ptr == '0))
        else $error("comparator outputs active during reset");

    // Overflow flag closes the window that a strobe opened
    err_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_err |-> $past(pkt_strobe, 3))
        else $error("pkt_err without a strobe three cycles earlier");

    ptr_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !ptr_hit_miss |-> ptr == '0)
        else $error("ptr not zero while ptr_hit_miss is low");

    // Keys at least four cycles apart
    strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_strobe |=> !pkt_strobe)
        else $error("pkt_strobe high for more than one cycle");

endmodule

bind class_hbkt_cmp class_lookup_asserts asserts0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .pkt_strobe   (pkt_strobe),
    .pkt_err      (pkt_err),
    .ptr_hit_miss (ptr_hit_miss),
    .ptr          (ptr)
);

`default_nettype wire

// ==== design/class_lookup_top.sv ====
// ======================================
// Cuckoo-hash lookup front end
// Hashing stage, bucket store, comparator
// ======================================
`timescale 1ns/1ps
`default_nettype none

module class_lookup_top
    import class_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        key_vld,
    input  logic [31:0] key,
    input  logic        tbl_wr_en,
    input  bkt_wr_t     tbl_wr,
    output logic        pkt_strobe,
    output logic        ptr_hit_miss,
    output ptr_t        ptr,
    output logic        pkt_err
);

    // Hash request into the tables
    hash_req_t req;

    // Flopped buckets with their hashes
    logic  ht_vld;
    hash_t h1k;
    hash_t h2k;
    bkt_t  ht_t1_data;
    bkt_t  ht_t2_data;

    class_key_hash key_hash0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .key_vld (key_vld),
        .key     (key),
        .req     (req)
    );

    class_hash_table hash_table0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .tbl_wr_en  (tbl_wr_en),
        .tbl_wr     (tbl_wr),
        .req        (req),
        .ht_vld     (ht_vld),
        .h1k        (h1k),
        .h2k        (h2k),
        .ht_t1_data (ht_t1_data),
        .ht_t2_data (ht_t2_data)
    );

    class_hbkt_cmp hbkt_cmp0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .h1k          (h1k),
        .h2k          (h2k),
        .ht_vld       (ht_vld),
        .ht_t1_data   (ht_t1_data),
        .ht_t2_data   (ht_t2_data),
        .pkt_strobe   (pkt_strobe),
        .pkt_err      (pkt_err),
        .ptr_hit_miss (ptr_hit_miss),
        .ptr          (ptr)
    );

endmodule

`default_nettype wire

// ==== design/class_hbkt_cmp.sv ====
// ======================================
// Bucket comparator
// Matches stored alternate hashes, returns
// up to four pointers and an overflow flag
// ======================================
`timescale 1ns/1ps
`default_nettype none

module class_hbkt_cmp
    import class_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  hash_t h1k,
    input  hash_t h2k,
    input  logic  ht_vld,
    input  bkt_t  ht_t1_data,
    input  bkt_t  ht_t2_data,
    output logic  pkt_strobe,
    output logic  pkt_err,
    output logic  ptr_hit_miss,
    output ptr_t  ptr
);

    // ======================================
    // Declarations
    // Way index: table 1 ways 0..3, then table 2 ways 0..3
    hash_t                  way_hash [MATCH_WIDTH];
    ptr_t                   way_ptr  [MATCH_WIDTH];
    logic [MATCH_WIDTH-1:0] way_vld;
    logic [MATCH_WIDTH-1:0] match_c;

    // Delay lines, index 1 is one cycle after ht_vld
    logic                   vld_q    [1:CMP_STAGES];
    logic [MATCH_WIDTH-1:0] match_q  [1:CMP_STAGES];
    ptr_t                   ptrs_q   [1:CMP_STAGES][MATCH_WIDTH];

    // Find-first-set chain
    logic [MATCH_WIDTH-1:0] mask_c   [CMP_STAGES];
    logic [MATCH_WIDTH-1:0] masked_c [CMP_STAGES];
    logic                   hit_c    [CMP_STAGES];
    logic [WIN_WIDTH-1:0]   win_c    [CMP_STAGES];
    // Last stage only feeds pkt_err, so no flop for it
    logic                   hit_q    [CMP_STAGES-1];
    logic [WIN_WIDTH-1:0]   win_q    [CMP_STAGES-1];

    // Lowest set bit, returned as {found, index}
    function automatic logic [WIN_WIDTH:0] ffs(input logic [MATCH_WIDTH-1:0] vec);
        logic                 found;
        logic [WIN_WIDTH-1:0] loc;
        found = 1'b0;
        loc   = '0;
        for (int i = MATCH_WIDTH - 1; i >= 0; i--)
        begin
            if (vec[i])
            begin
                found = 1'b1;
                loc   = WIN_WIDTH'(i);
            end
        end
        return {found, loc};
    endfunction

    // Ones strictly above index
    function automatic logic [MATCH_WIDTH-1:0] make_mask(input logic [WIN_WIDTH-1:0] idx);
        logic [MATCH_WIDTH-1:0] m;
        for (int i = 0; i < MATCH_WIDTH; i++)
            m[i] = (i > int'(idx));
        return m;
    endfunction

    // ======================================
    // Way unpack and hash compare
    always_comb
    begin
        for (int i = 0; i < WAYS; i++)
        begin
            way_hash[i]      = ht_t1_data[i*WAY_WIDTH +: HASH_WIDTH];
            way_ptr[i]       = ht_t1_data[i*WAY_WIDTH + WAY_PTR_LSB +: PTR_WIDTH];
            way_vld[i]       = ht_t1_data[i*WAY_WIDTH + WAY_VLD_BIT];
            way_hash[i+WAYS] = ht_t2_data[i*WAY_WIDTH +: HASH_WIDTH];
            way_ptr[i+WAYS]  = ht_t2_data[i*WAY_WIDTH + WAY_PTR_LSB +: PTR_WIDTH];
            way_vld[i+WAYS]  = ht_t2_data[i*WAY_WIDTH + WAY_VLD_BIT];
        end
    end

    // Table 1 holds h2k as alternate, table 2 holds h1k
    always_comb
    begin
        for (int i = 0; i < WAYS; i++)
        begin
            match_c[i]      = way_vld[i] && (way_hash[i] == h2k);
            match_c[i+WAYS] = way_vld[i+WAYS] && (way_hash[i+WAYS] == h1k);
        end
    end

    // Each stage skips bits at and below the previous winner
    // A stage with no hit blanks everything after it
    always_comb
    begin
        mask_c[0] = '1;
        for (int s = 1; s < CMP_STAGES; s++)
            mask_c[s] = hit_q[s-1] ? make_mask(win_q[s-1]) : '0;
        for (int s = 0; s < CMP_STAGES; s++)
        begin
            masked_c[s]          = match_q[s+1] & mask_c[s];
            {hit_c[s], win_c[s]} = ffs(masked_c[s]);
        end
    end

    // ======================================
    // Pipeline registers
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int k = 1; k <= CMP_STAGES; k++)
            begin
                vld_q[k]   <= 1'b0;
                match_q[k] <= '0;
            end
        end
        else
        begin
            vld_q[1]   <= ht_vld;
            match_q[1] <= ht_vld ? match_c : '0;
            for (int k = 2; k <= CMP_STAGES; k++)
            begin
                vld_q[k]   <= vld_q[k-1];
                match_q[k] <= match_q[k-1];
            end
        end
    end

    // Pointer copies follow the match vector
    always_ff @(posedge clk)
    begin
        if (ht_vld)
            ptrs_q[1] <= way_ptr;
        for (int k = 2; k <= CMP_STAGES; k++)
            ptrs_q[k] <= ptrs_q[k-1];
    end

    // Winner flops, one per slot
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < CMP_STAGES - 1; s++)
            begin
                hit_q[s] <= 1'b0;
                win_q[s] <= '0;
            end
        end
        else
        begin
            for (int s = 0; s < CMP_STAGES - 1; s++)
            begin
                if (vld_q[s+1])
                begin
                    hit_q[s] <= hit_c[s];
                    win_q[s] <= win_c[s];
                end
            end
        end
    end

    // ======================================
    // Outputs
    // Strobe on first result cycle, error on the fourth
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pkt_strobe <= 1'b0;
            pkt_err    <= 1'b0;
        end
        else
        begin
            pkt_strobe <= vld_q[2];
            // Fifth match still left after four winners
            pkt_err    <= vld_q[CMP_STAGES] && hit_c[CMP_STAGES-1];
        end
    end

    // One pointer slot per cycle, zero when idle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ptr          <= '0;
            ptr_hit_miss <= 1'b0;
        end
        else
        begin
            ptr          <= '0;
            ptr_hit_miss <= 1'b0;
            for (int s = 0; s < CMP_STAGES - 1; s++)
            begin
                if (vld_q[s+2] && hit_q[s])
                begin
                    ptr          <= ptrs_q[s+2][win_q[s]];
                    ptr_hit_miss <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/class_hash_table.sv ====
// ======================================
// Two-table bucket store
// 64 buckets per table, plain load port,
// registered read aligned with the hashes
// ======================================
`timescale 1ns/1ps
`default_nettype none

module class_hash_table
    import class_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tbl_wr_en,
    input  bkt_wr_t   tbl_wr,
    input  hash_req_t req,
    output logic      ht_vld,
    output hash_t     h1k,
    output hash_t     h2k,
    output bkt_t      ht_t1_data,
    output bkt_t      ht_t2_data
);

    // ======================================
    // Bucket arrays
    bkt_t t1_mem [NUM_BKTS];
    bkt_t t2_mem [NUM_BKTS];

    // Bucket indices from the low hash bits
    bkt_addr_t t1_addr;
    bkt_addr_t t2_addr;

    assign t1_addr = req.h1k[BKT_ADDR_WIDTH-1:0];
    assign t2_addr = req.h2k[BKT_ADDR_WIDTH-1:0];

    // Load port, table select picks the array
    always_ff @(posedge clk)
    begin
        if (tbl_wr_en)
        begin
            if (tbl_wr.tbl_sel)
                t2_mem[tbl_wr.addr] <= tbl_wr.data;
            else
                t1_mem[tbl_wr.addr] <= tbl_wr.data;
        end
    end

    // ======================================
    // Read side
    // Same-cycle write to the bucket read here returns old data
    always_ff @(posedge clk)
    begin
        if (req.vld)
        begin
            ht_t1_data <= t1_mem[t1_addr];
            ht_t2_data <= t2_mem[t2_addr];
            // Hashes travel with the bucket data
            h1k        <= req.h1k;
            h2k        <= req.h2k;
        end
    end

    // Valid lines up with the flopped buckets
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ht_vld <= 1'b0;
        else
            ht_vld <= req.vld;
    end

endmodule

`default_nettype wire

// ==== design/class_key_hash.sv ====
// ======================================
// Key hashing stage
// Folds a 32-bit flow key into two 13-bit
// hashes and issues the bucket read
// ======================================
`timescale 1ns/1ps
`default_nettype none

module class_key_hash
    import class_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        key_vld,
    input  logic [31:0] key,
    output hash_req_t   req
);

    // Unregistered hashes
    hash_t h1k_c;
    hash_t h2k_c;

    // XOR fold of three key slices, top slice zero-extended
    function automatic hash_t fold(input logic [31:0] k);
        hash_t top;
        top = hash_t'(k[31:26]);
        return k[12:0] ^ k[25:13] ^ top;
    endfunction

    // Second hash works on the key rotated left by 7
    assign h1k_c = fold(key);
    assign h2k_c = fold({key[24:0], key[31:25]});

    // Request valid
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            req.vld <= 1'b0;
        else
            req.vld <= key_vld;
    end

    // Hash fields hold between keys
    always_ff @(posedge clk)
    begin
        if (key_vld)
        begin
            req.h1k <= h1k_c;
            req.h2k <= h2k_c;
        end
    end

endmodule

`default_nettype wire

// ==== design/class_pkg.sv ====
// ======================================
// Classifier lookup package
// Widths, word layout and shared types for
// the cuckoo-hash lookup front end
// ======================================
`default_nettype none

package class_pkg;

    // ======================================
    // Widths
    localparam int HASH_WIDTH     = 13;
    localparam int PTR_WIDTH      = 15;
    localparam int WAYS           = 4;
    localparam int BKT_ADDR_WIDTH = 6;
    localparam int BKT_WIDTH      = 128;

    // Way layout: {vld, ptr[14:0], 3'b000, hash[12:0]}
    localparam int WAY_WIDTH      = BKT_WIDTH / WAYS;
    localparam int WAY_PTR_LSB    = 16;
    localparam int WAY_VLD_BIT    = 31;

    // Derived sizes
    localparam int NUM_BKTS       = 2 ** BKT_ADDR_WIDTH;
    localparam int MATCH_WIDTH    = 2 * WAYS;
    localparam int WIN_WIDTH      = $clog2(MATCH_WIDTH);
    // Four pointer slots plus one overflow check
    localparam int CMP_STAGES     = 5;

    // ======================================
    // Types
    typedef logic [HASH_WIDTH-1:0]     hash_t;
    typedef logic [PTR_WIDTH-1:0]      ptr_t;
    typedef logic [BKT_ADDR_WIDTH-1:0] bkt_addr_t;
    typedef logic [BKT_WIDTH-1:0]      bkt_t;

    // Table load, tbl_sel 0 picks table 1
    typedef struct packed {
        logic      tbl_sel;
        bkt_addr_t addr;
        bkt_t      data;
    } bkt_wr_t;

    // Lookup in flight
    typedef struct packed {
        logic  vld;
        hash_t h1k;
        hash_t h2k;
    } hash_req_t;

endpackage

`default_nettype wire
